/* hdl/fe_pkg.sv */
package fe_pkg;

  localparam int XLEN     = 64;
  localparam int INST_LEN = 32;
  localparam int TRAP_LEN = 3;

  // trap bus bit positions.
  localparam int TRAP_FETCH_MISALIGN = 0;
  localparam int TRAP_FETCH_FAULT    = 1;
  localparam int TRAP_ILLEGAL        = 2;

  localparam int STAGE_NUM    = 6;
  localparam int STAGE_PC     = 0;
  localparam int STAGE_IF_ID  = 1;
  localparam int STAGE_ID_EX  = 2;
  localparam int STAGE_EX_MEM = 3;
  localparam int STAGE_MEM_WB = 4;
  localparam int STAGE_WB     = 5;

  localparam logic [INST_LEN-1:0] INST_NOP = 32'h0000_0013; // addi x0, x0, 0.

  localparam logic [6:0] OPC_LOAD      = 7'b000_0011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b001_0011;
  localparam logic [6:0] OPC_AUIPC     = 7'b001_0111;
  localparam logic [6:0] OPC_STORE     = 7'b010_0011;
  localparam logic [6:0] OPC_OP        = 7'b011_0011;
  localparam logic [6:0] OPC_LUI       = 7'b011_0111;
  localparam logic [6:0] OPC_BRANCH    = 7'b110_0011;
  localparam logic [6:0] OPC_JALR      = 7'b110_0111;
  localparam logic [6:0] OPC_JAL       = 7'b110_1111;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b001_1011;
  localparam logic [6:0] OPC_OP_32     = 7'b011_1011;
  localparam logic [6:0] OPC_SYSTEM    = 7'b111_0011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // same word seen raw or through one of the format layouts.
  typedef union packed {
    logic [INST_LEN-1:0] raw;
    r_fmt_t              r_fmt;
    i_fmt_t              i_fmt;
    s_fmt_t              s_fmt;
    b_fmt_t              b_fmt;
    u_fmt_t              u_fmt;
    j_fmt_t              j_fmt;
  } inst_u;

endpackage

/* hdl/pc_gen.sv */
`timescale 1ns/100ps

module pc_gen #(
  parameter logic [fe_pkg::XLEN-1:0] RESET_ADDR = 'h8000_0000
) (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    stall_i,
  input  logic                    redirect_valid_i,
  input  logic [fe_pkg::XLEN-1:0] redirect_pc_i,
  output logic [fe_pkg::XLEN-1:0] pc_o
);

  // one slot before the boot address that if_id turns into a bubble.
  localparam logic [fe_pkg::XLEN-1:0] BOOT_PC = RESET_ADDR - 4;

  logic [fe_pkg::XLEN-1:0] pc_q;
  logic [fe_pkg::XLEN-1:0] pc_d;

  always_comb begin
    if (redirect_valid_i) begin
      pc_d = redirect_pc_i;
    end else begin
      pc_d = pc_q + fe_pkg::XLEN'(4); // next sequential word.
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= BOOT_PC;
    end else if (!stall_i) begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

/* hdl/inst_fetch.sv */
`timescale 1ns/100ps

module inst_fetch (
  input  logic [fe_pkg::XLEN-1:0]     pc_i,
  output logic [fe_pkg::XLEN-1:0]     imem_addr_o,
  input  logic [fe_pkg::INST_LEN-1:0] imem_data_i,
  input  logic                        imem_err_i,
  output logic [fe_pkg::XLEN-1:0]     inst_addr_o,
  output fe_pkg::inst_u               inst_data_o,
  output logic [fe_pkg::TRAP_LEN-1:0] trap_o
);

  logic misalign;
  logic fault;

  assign imem_addr_o = pc_i;
  assign inst_addr_o = pc_i;

  assign misalign = |pc_i[1:0];
  assign fault    = imem_err_i & ~misalign; // misalignment wins.

  always_comb begin
    trap_o = '0;
    trap_o[fe_pkg::TRAP_FETCH_MISALIGN] = misalign;
    trap_o[fe_pkg::TRAP_FETCH_FAULT]    = fault;
  end

  // a failed fetch must not decode as an illegal opcode.
  always_comb begin
    if (misalign || fault) begin
      inst_data_o = fe_pkg::INST_NOP;
    end else begin
      inst_data_o = imem_data_i;
    end
  end

endmodule

/* hdl/pipe_ctrl.sv */
`timescale 1ns/100ps

module pipe_ctrl (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         exe_busy_i,
  input  logic                         redirect_valid_i,
  output logic [fe_pkg::STAGE_NUM-1:0] stall_o,
  output logic [fe_pkg::STAGE_NUM-1:0] flush_o
);

  always_comb begin
    stall_o = '0;
    flush_o = '0;
    // busy execute stage holds everything up to ID/EX.
    stall_o[fe_pkg::STAGE_PC]    = exe_busy_i;
    stall_o[fe_pkg::STAGE_IF_ID] = exe_busy_i;
    stall_o[fe_pkg::STAGE_ID_EX] = exe_busy_i;
    // redirect kills the wrong path in IF/ID and ID/EX.
    flush_o[fe_pkg::STAGE_IF_ID] = redirect_valid_i;
    flush_o[fe_pkg::STAGE_ID_EX] = redirect_valid_i;
  end

  // execute stage may not redirect while it is busy.
  a_no_redirect_when_busy : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !(exe_busy_i && redirect_valid_i)
  ) else $error("redirect strobe while execute stage busy");

  a_stall_flush_excl : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (stall_o & flush_o) == '0
  ) else $error("stall and flush set for one stage: %b %b", stall_o, flush_o);

endmodule

/* hdl/if_id.sv */
`timescale 1ns/100ps

module if_id #(
  parameter logic [fe_pkg::XLEN-1:0] RESET_ADDR = 'h8000_0000
) (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic [fe_pkg::STAGE_NUM-1:0] stall_i,
  input  logic [fe_pkg::STAGE_NUM-1:0] flush_i,
  input  logic [fe_pkg::XLEN-1:0]      inst_addr_i,
  input  fe_pkg::inst_u                inst_data_i,
  input  logic [fe_pkg::TRAP_LEN-1:0]  trap_i,
  output logic [fe_pkg::XLEN-1:0]      inst_addr_o,
  output fe_pkg::inst_u                inst_data_o,
  output logic [fe_pkg::TRAP_LEN-1:0]  trap_o
);

  localparam logic [fe_pkg::XLEN-1:0] BOOT_PC = RESET_ADDR - 4;

  logic                        reg_wen;
  logic                        flush;
  logic [fe_pkg::XLEN-1:0]     inst_addr_q;
  fe_pkg::inst_u               inst_data_q;
  logic [fe_pkg::TRAP_LEN-1:0] trap_q;

  assign reg_wen = !stall_i[fe_pkg::STAGE_IF_ID]; // hold while stalled.

  // the pre-boot slot from pc_gen never reaches decode.
  assign flush = flush_i[fe_pkg::STAGE_IF_ID] | (inst_addr_i == BOOT_PC);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inst_addr_q <= '0;
      inst_data_q <= fe_pkg::INST_NOP;
      trap_q      <= '0;
    end else if (reg_wen) begin
      if (flush) begin
        inst_addr_q <= '0; // bubble.
        inst_data_q <= fe_pkg::INST_NOP;
        trap_q      <= '0;
      end else begin
        inst_addr_q <= inst_addr_i;
        inst_data_q <= inst_data_i;
        trap_q      <= trap_i;
      end
    end
  end

  assign inst_addr_o = inst_addr_q;
  assign inst_data_o = inst_data_q;
  assign trap_o      = trap_q;

endmodule

/* hdl/inst_decode.sv */
`timescale 1ns/100ps

module inst_decode (
  input  logic [fe_pkg::XLEN-1:0]     inst_addr_i,
  input  fe_pkg::inst_u               inst_data_i,
  input  logic [fe_pkg::TRAP_LEN-1:0] trap_i,
  output logic [4:0]                  rd_o,
  output logic [4:0]                  rs1_o,
  output logic [4:0]                  rs2_o,
  output logic [fe_pkg::XLEN-1:0]     imm_o,
  output logic [fe_pkg::TRAP_LEN-1:0] trap_o
);

  logic [6:0]         opcode;
  logic               opc_known;
  logic               illegal;
  logic               fetch_trap;
  logic signed [11:0] imm_i;
  logic signed [11:0] imm_s;
  logic signed [12:0] imm_b;
  logic signed [31:0] imm_u;
  logic signed [20:0] imm_j;

  assign opcode = inst_data_i.r_fmt.opcode;

  // raw immediates per format with the implied zero lsb for B and J.
  assign imm_i = inst_data_i.i_fmt.imm_11_0;
  assign imm_s = {inst_data_i.s_fmt.imm_11_5, inst_data_i.s_fmt.imm_4_0};
  assign imm_b = {inst_data_i.b_fmt.imm_12, inst_data_i.b_fmt.imm_11,
                  inst_data_i.b_fmt.imm_10_5, inst_data_i.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst_data_i.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {inst_data_i.j_fmt.imm_20, inst_data_i.j_fmt.imm_19_12,
                  inst_data_i.j_fmt.imm_11, inst_data_i.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    rd_o      = '0;
    rs1_o     = '0;
    rs2_o     = '0;
    imm_o     = '0;
    opc_known = 1'b1;
    case (opcode)
      fe_pkg::OPC_OP, fe_pkg::OPC_OP_32: begin
        rd_o  = inst_data_i.r_fmt.rd;
        rs1_o = inst_data_i.r_fmt.rs1;
        rs2_o = inst_data_i.r_fmt.rs2;
      end
      fe_pkg::OPC_LOAD, fe_pkg::OPC_OP_IMM, fe_pkg::OPC_OP_IMM_32,
      fe_pkg::OPC_JALR, fe_pkg::OPC_SYSTEM: begin
        rd_o  = inst_data_i.i_fmt.rd;
        rs1_o = inst_data_i.i_fmt.rs1;
        imm_o = fe_pkg::XLEN'(imm_i);
      end
      fe_pkg::OPC_STORE: begin
        rs1_o = inst_data_i.s_fmt.rs1;
        rs2_o = inst_data_i.s_fmt.rs2;
        imm_o = fe_pkg::XLEN'(imm_s);
      end
      fe_pkg::OPC_BRANCH: begin
        rs1_o = inst_data_i.b_fmt.rs1;
        rs2_o = inst_data_i.b_fmt.rs2;
        imm_o = fe_pkg::XLEN'(imm_b);
      end
      fe_pkg::OPC_LUI, fe_pkg::OPC_AUIPC: begin
        rd_o  = inst_data_i.u_fmt.rd;
        imm_o = fe_pkg::XLEN'(imm_u); // sign-extended on rv64.
      end
      fe_pkg::OPC_JAL: begin
        rd_o  = inst_data_i.j_fmt.rd;
        imm_o = fe_pkg::XLEN'(imm_j);
      end
      default: opc_known = 1'b0;
    endcase
  end

  assign illegal = (opcode[1:0] != 2'b11) | ~opc_known; // compressed not supported.

  always_comb begin
    trap_o = trap_i;
    trap_o[fe_pkg::TRAP_ILLEGAL] = trap_i[fe_pkg::TRAP_ILLEGAL] | illegal;
  end

  assign fetch_trap = trap_i[fe_pkg::TRAP_FETCH_MISALIGN] | trap_i[fe_pkg::TRAP_FETCH_FAULT];

  // fetch traps arrive through if_id with the word already replaced.
  a_fetch_trap_nop : assert final (
    !fetch_trap || (inst_data_i.raw == fe_pkg::INST_NOP &&
    (!trap_i[fe_pkg::TRAP_FETCH_MISALIGN] || inst_addr_i[1:0] != 2'b00))
  ) else $error("fetch trap with bad word %h at pc %h", inst_data_i.raw, inst_addr_i);

endmodule

/* hdl/fe_top.sv */
`timescale 1ns/100ps

module fe_top #(
  parameter logic [fe_pkg::XLEN-1:0] RESET_ADDR = 'h8000_0000
) (
  input  logic                         clk,
  input  logic                         arst_n_i,
  output logic [fe_pkg::XLEN-1:0]      imem_addr_o,
  input  logic [fe_pkg::INST_LEN-1:0]  imem_data_i,
  input  logic                         imem_err_i,
  input  logic                         exe_busy_i,
  input  logic                         redirect_valid_i,
  input  logic [fe_pkg::XLEN-1:0]      redirect_pc_i,
  output logic [fe_pkg::STAGE_NUM-1:0] stall_o,
  output logic [fe_pkg::STAGE_NUM-1:0] flush_o,
  output logic [fe_pkg::XLEN-1:0]      id_pc_o,
  output logic [fe_pkg::INST_LEN-1:0]  id_inst_o,
  output logic [4:0]                   id_rd_o,
  output logic [4:0]                   id_rs1_o,
  output logic [4:0]                   id_rs2_o,
  output logic [fe_pkg::XLEN-1:0]      id_imm_o,
  output logic [fe_pkg::TRAP_LEN-1:0]  id_trap_o
);

  logic [fe_pkg::STAGE_NUM-1:0] stall;
  logic [fe_pkg::STAGE_NUM-1:0] flush;
  logic [fe_pkg::XLEN-1:0]      fetch_pc;
  logic [fe_pkg::XLEN-1:0]      if_addr;
  fe_pkg::inst_u                if_inst;
  logic [fe_pkg::TRAP_LEN-1:0]  if_trap;
  logic [fe_pkg::XLEN-1:0]      id_addr;
  fe_pkg::inst_u                id_inst;
  logic [fe_pkg::TRAP_LEN-1:0]  id_trap;

  pc_gen #(.RESET_ADDR(RESET_ADDR)) u_pc_gen (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .stall_i          (stall[fe_pkg::STAGE_PC]),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .pc_o             (fetch_pc)
  );

  inst_fetch u_inst_fetch (
    .pc_i        (fetch_pc),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .imem_err_i  (imem_err_i),
    .inst_addr_o (if_addr),
    .inst_data_o (if_inst),
    .trap_o      (if_trap)
  );

  pipe_ctrl u_pipe_ctrl (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .exe_busy_i       (exe_busy_i),
    .redirect_valid_i (redirect_valid_i),
    .stall_o          (stall),
    .flush_o          (flush)
  );

  if_id #(.RESET_ADDR(RESET_ADDR)) u_if_id (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .stall_i     (stall),
    .flush_i     (flush),
    .inst_addr_i (if_addr),
    .inst_data_i (if_inst),
    .trap_i      (if_trap),
    .inst_addr_o (id_addr),
    .inst_data_o (id_inst),
    .trap_o      (id_trap)
  );

  inst_decode u_inst_decode (
    .inst_addr_i (id_addr),
    .inst_data_i (id_inst),
    .trap_i      (id_trap),
    .rd_o        (id_rd_o),
    .rs1_o       (id_rs1_o),
    .rs2_o       (id_rs2_o),
    .imm_o       (id_imm_o),
    .trap_o      (id_trap_o)
  );

  assign stall_o   = stall; // downstream stages.
  assign flush_o   = flush;
  assign id_pc_o   = id_addr;
  assign id_inst_o = id_inst.raw;

endmodule

/* sim/tb_fe_model.svh */
`ifndef TB_FE_MODEL_SVH
`define TB_FE_MODEL_SVH

// shadow fetch pc and if/id register.
logic [fe_pkg::XLEN-1:0]     m_pc;
logic [fe_pkg::XLEN-1:0]     m_id_pc;
fe_pkg::inst_u               m_id_inst;
logic [fe_pkg::TRAP_LEN-1:0] m_id_trap;

function automatic logic in_mem(input logic [fe_pkg::XLEN-1:0] addr);
  return (addr >= MEM_BASE) && (addr < MEM_BASE + 4 * MEM_WORDS);
endfunction

function automatic int word_idx(input logic [fe_pkg::XLEN-1:0] addr);
  return int'((addr - MEM_BASE) >> 2) % MEM_WORDS;
endfunction

task automatic model_reset();
  m_pc      = RESET_ADDR - 4;
  m_id_pc   = '0;
  m_id_inst = fe_pkg::INST_NOP;
  m_id_trap = '0;
endtask

// one rising edge with the inputs that were held before it.
task automatic model_step(input logic busy, input logic redir,
                          input logic [fe_pkg::XLEN-1:0] target);
  logic misalign;
  logic fault;
  if (busy) return;
  misalign = (m_pc[1:0] != 2'b00);
  fault    = !misalign && !in_mem(m_pc);
  if (redir || m_pc == RESET_ADDR - 4) begin
    m_id_pc   = '0; // bubble.
    m_id_inst = fe_pkg::INST_NOP;
    m_id_trap = '0;
  end else begin
    m_id_pc   = m_pc;
    m_id_inst = (misalign || fault) ? fe_pkg::INST_NOP : mem[word_idx(m_pc)];
    m_id_trap = '0;
    m_id_trap[fe_pkg::TRAP_FETCH_MISALIGN] = misalign;
    m_id_trap[fe_pkg::TRAP_FETCH_FAULT]    = fault;
  end
  m_pc = redir ? target : m_pc + 4;
endtask

task automatic decode_ref(input logic [31:0] w, output logic [4:0] rd,
                          output logic [4:0] rs1, output logic [4:0] rs2,
                          output logic [fe_pkg::XLEN-1:0] imm, output logic illegal);
  rd      = '0;
  rs1     = '0;
  rs2     = '0;
  imm     = '0;
  illegal = (w[1:0] != 2'b11);
  case (w[6:0])
    fe_pkg::OPC_OP, fe_pkg::OPC_OP_32: begin
      rd  = w[11:7];
      rs1 = w[19:15];
      rs2 = w[24:20];
    end
    fe_pkg::OPC_LOAD, fe_pkg::OPC_OP_IMM, fe_pkg::OPC_OP_IMM_32,
    fe_pkg::OPC_JALR, fe_pkg::OPC_SYSTEM: begin
      rd  = w[11:7];
      rs1 = w[19:15];
      imm = {{52{w[31]}}, w[31:20]};
    end
    fe_pkg::OPC_STORE: begin
      rs1 = w[19:15];
      rs2 = w[24:20];
      imm = {{52{w[31]}}, w[31:25], w[11:7]};
    end
    fe_pkg::OPC_BRANCH: begin
      rs1 = w[19:15];
      rs2 = w[24:20];
      imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    end
    fe_pkg::OPC_LUI, fe_pkg::OPC_AUIPC: begin
      rd  = w[11:7];
      imm = {{32{w[31]}}, w[31:12], 12'h000};
    end
    fe_pkg::OPC_JAL: begin
      rd  = w[11:7];
      imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    end
    default: illegal = 1'b1;
  endcase
endtask

task automatic check_pc(input logic [fe_pkg::XLEN-1:0] got, input logic [fe_pkg::XLEN-1:0] exp,
                        input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR at %0t ns: %s pc %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_inst(input fe_pkg::inst_u got, input fe_pkg::inst_u exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR at %0t ns: instruction %h, expected %h", $time, got.raw, exp.raw);
  end
endtask

task automatic check_fields(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [fe_pkg::XLEN-1:0] imm, input logic [4:0] e_rd,
                            input logic [4:0] e_rs1, input logic [4:0] e_rs2,
                            input logic [fe_pkg::XLEN-1:0] e_imm);
  chk_cnt++;
  if ({rd, rs1, rs2, imm} !== {e_rd, e_rs1, e_rs2, e_imm}) begin
    err_cnt++;
    $display("ERROR at %0t ns: fields rd %0d rs1 %0d rs2 %0d imm %h, expected %0d %0d %0d %h",
             $time, rd, rs1, rs2, imm, e_rd, e_rs1, e_rs2, e_imm);
  end
endtask

task automatic check_trap(input logic [fe_pkg::TRAP_LEN-1:0] got,
                          input logic [fe_pkg::TRAP_LEN-1:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR at %0t ns: trap bus %b, expected %b", $time, got, exp);
  end
endtask

task automatic check_bus(input logic [fe_pkg::STAGE_NUM-1:0] got,
                         input logic [fe_pkg::STAGE_NUM-1:0] exp, input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR at %0t ns: %s bus %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

/* sim/tb_fe_top.sv */
`timescale 1ns/100ps

module tb_fe_top;

  localparam logic [fe_pkg::XLEN-1:0] RESET_ADDR = 64'h0000_0000_8000_0000;
  localparam logic [fe_pkg::XLEN-1:0] MEM_BASE   = RESET_ADDR;
  localparam int MEM_WORDS = 256;
  localparam int SEQ_LEN   = 200;
  localparam int BP_LEN    = 150;
  localparam int REDIR_NUM = 40;
  localparam int TRAP_NUM  = 20;
  localparam int ILL_LEN   = 200;
  // reset, boot, then every redirect or trap round takes four cycles.
  localparam int CYCLE_LIMIT = 7 + (SEQ_LEN + 1) + (BP_LEN + 1) + 4 * REDIR_NUM
                             + 4 * TRAP_NUM + (ILL_LEN + 1) + 100;

  logic                         clk;
  logic                         arst_n;
  logic [fe_pkg::XLEN-1:0]      imem_addr;
  logic [fe_pkg::INST_LEN-1:0]  imem_data;
  logic                         imem_err;
  logic                         exe_busy;
  logic                         redirect_valid;
  logic [fe_pkg::XLEN-1:0]      redirect_pc;
  logic [fe_pkg::STAGE_NUM-1:0] stall;
  logic [fe_pkg::STAGE_NUM-1:0] flush;
  logic [fe_pkg::XLEN-1:0]      id_pc;
  logic [fe_pkg::INST_LEN-1:0]  id_inst;
  logic [4:0]                   id_rd;
  logic [4:0]                   id_rs1;
  logic [4:0]                   id_rs2;
  logic [fe_pkg::XLEN-1:0]      id_imm;
  logic [fe_pkg::TRAP_LEN-1:0]  id_trap;
  logic [fe_pkg::INST_LEN-1:0]  mem [MEM_WORDS];
  int unsigned                  err_cnt;
  int unsigned                  chk_cnt;
  int unsigned                  ill_cnt;
  int unsigned                  cyc_cnt;

  `include "tb_fe_model.svh"

  fe_top #(.RESET_ADDR(RESET_ADDR)) u_dut (
    .clk              (clk),
    .arst_n_i         (arst_n),
    .imem_addr_o      (imem_addr),
    .imem_data_i      (imem_data),
    .imem_err_i       (imem_err),
    .exe_busy_i       (exe_busy),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .stall_o          (stall),
    .flush_o          (flush),
    .id_pc_o          (id_pc),
    .id_inst_o        (id_inst),
    .id_rd_o          (id_rd),
    .id_rs1_o         (id_rs1),
    .id_rs2_o         (id_rs2),
    .id_imm_o         (id_imm),
    .id_trap_o        (id_trap)
  );

  // combinational memory with an error outside its range.
  assign imem_err  = !in_mem(imem_addr);
  assign imem_data = in_mem(imem_addr) ? mem[word_idx(imem_addr)] : 32'hffff_ffff;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [6:0] pick_opcode(input int k);
    case (k)
      0:  return fe_pkg::OPC_LOAD;
      1:  return fe_pkg::OPC_OP_IMM;
      2:  return fe_pkg::OPC_AUIPC;
      3:  return fe_pkg::OPC_STORE;
      4:  return fe_pkg::OPC_OP;
      5:  return fe_pkg::OPC_LUI;
      6:  return fe_pkg::OPC_BRANCH;
      7:  return fe_pkg::OPC_JALR;
      8:  return fe_pkg::OPC_JAL;
      9:  return fe_pkg::OPC_OP_IMM_32;
      10: return fe_pkg::OPC_OP_32;
      default: return fe_pkg::OPC_SYSTEM;
    endcase
  endfunction

  task automatic fill_mem();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = $urandom;
      if (i % 4 == 0) mem[i][6:0] = pick_opcode($urandom_range(0, 11)); // legal quarter.
    end
  endtask

  function automatic logic [fe_pkg::XLEN-1:0] rand_target();
    return MEM_BASE + fe_pkg::XLEN'(4 * $urandom_range(0, MEM_WORDS - 1));
  endfunction

  // runs from posedge + 2 to the next posedge + 2.
  task automatic run_cycle(input logic busy, input logic redir,
                           input logic [fe_pkg::XLEN-1:0] target);
    logic [4:0]                   rd;
    logic [4:0]                   rs1;
    logic [4:0]                   rs2;
    logic [fe_pkg::XLEN-1:0]      imm;
    logic                         illegal;
    logic [fe_pkg::TRAP_LEN-1:0]  exp_trap;
    logic [fe_pkg::STAGE_NUM-1:0] exp_stall;
    logic [fe_pkg::STAGE_NUM-1:0] exp_flush;
    exe_busy       = busy;
    redirect_valid = redir;
    redirect_pc    = target;
    @(negedge clk);
    decode_ref(m_id_inst.raw, rd, rs1, rs2, imm, illegal);
    exp_trap = m_id_trap;
    exp_trap[fe_pkg::TRAP_ILLEGAL] = illegal;
    exp_stall = '0;
    exp_flush = '0;
    exp_stall[fe_pkg::STAGE_PC]    = busy;
    exp_stall[fe_pkg::STAGE_IF_ID] = busy;
    exp_stall[fe_pkg::STAGE_ID_EX] = busy;
    exp_flush[fe_pkg::STAGE_IF_ID] = redir;
    exp_flush[fe_pkg::STAGE_ID_EX] = redir;
    check_pc(imem_addr, m_pc, "fetch");
    check_pc(id_pc, m_id_pc, "decode");
    check_inst(id_inst, m_id_inst);
    check_fields(id_rd, id_rs1, id_rs2, id_imm, rd, rs1, rs2, imm);
    check_trap(id_trap, exp_trap);
    check_bus(stall, exp_stall, "stall");
    check_bus(flush, exp_flush, "flush");
    if (illegal) ill_cnt++;
    @(posedge clk);
    model_step(busy, redir, target);
    #2;
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    $display("test %s done with %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic test_reset();
    int unsigned errs;
    errs = err_cnt;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_bus(stall, '0, "stall in reset");
    check_bus(flush, '0, "flush in reset");
    check_pc(id_pc, '0, "reset");
    check_inst(id_inst, fe_pkg::INST_NOP);
    @(posedge clk);
    #2;
    arst_n = 1'b1;
    run_cycle(1'b0, 1'b0, '0);
    run_cycle(1'b0, 1'b0, '0);
    check_pc(id_pc, RESET_ADDR, "boot");
    run_cycle(1'b0, 1'b0, '0);
    report_test("reset bubble", errs);
  endtask

  task automatic test_sequential();
    int unsigned             errs;
    logic [fe_pkg::XLEN-1:0] prev;
    errs = err_cnt;
    for (int i = 0; i < SEQ_LEN; i++) begin
      prev = m_id_pc;
      run_cycle(1'b0, 1'b0, '0);
      check_pc(id_pc, prev + 4, "sequential");
    end
    report_test("sequential flow", errs);
  endtask

  task automatic test_backpressure();
    int unsigned             errs;
    logic                    busy;
    logic [fe_pkg::XLEN-1:0] held_pc;
    fe_pkg::inst_u           held_inst;
    errs = err_cnt;
    run_cycle(1'b0, 1'b1, MEM_BASE);
    for (int i = 0; i < BP_LEN; i++) begin
      busy      = $urandom_range(0, 1);
      held_pc   = m_id_pc;
      held_inst = m_id_inst;
      run_cycle(busy, 1'b0, '0);
      if (busy) begin
        check_pc(id_pc, held_pc, "held");
        check_inst(id_inst, held_inst);
      end
    end
    report_test("back-pressure", errs);
  endtask

  task automatic test_redirect();
    int unsigned             errs;
    logic [fe_pkg::XLEN-1:0] target;
    errs = err_cnt;
    for (int i = 0; i < REDIR_NUM; i++) begin
      target = rand_target();
      run_cycle(1'b0, 1'b1, target);
      check_pc(id_pc, '0, "flushed");
      check_inst(id_inst, fe_pkg::INST_NOP);
      run_cycle(1'b0, 1'b0, '0);
      check_pc(id_pc, target, "redirect target");
      run_cycle(1'b0, 1'b0, '0);
      run_cycle(1'b0, 1'b0, '0);
    end
    report_test("redirect", errs);
  endtask

  task automatic test_fetch_trap();
    int unsigned                 errs;
    logic [fe_pkg::XLEN-1:0]     target;
    logic [fe_pkg::TRAP_LEN-1:0] exp_trap;
    errs = err_cnt;
    for (int i = 0; i < TRAP_NUM; i++) begin
      exp_trap = '0;
      if (i % 2 == 0) begin
        target = rand_target() + fe_pkg::XLEN'($urandom_range(1, 3));
        exp_trap[fe_pkg::TRAP_FETCH_MISALIGN] = 1'b1;
      end else begin
        target = rand_target() + fe_pkg::XLEN'(4 * MEM_WORDS); // past the end.
        exp_trap[fe_pkg::TRAP_FETCH_FAULT] = 1'b1;
      end
      run_cycle(1'b0, 1'b1, target);
      run_cycle(1'b0, 1'b0, '0);
      check_pc(id_pc, target, "trap target");
      check_inst(id_inst, fe_pkg::INST_NOP);
      check_trap(id_trap, exp_trap);
      run_cycle(1'b0, 1'b0, '0);
      run_cycle(1'b0, 1'b0, '0);
    end
    report_test("fetch traps", errs);
  endtask

  task automatic test_illegal();
    int unsigned errs;
    errs    = err_cnt;
    ill_cnt = 0;
    run_cycle(1'b0, 1'b1, MEM_BASE);
    for (int i = 0; i < ILL_LEN; i++) begin
      run_cycle(1'b0, 1'b0, '0);
    end
    if (ill_cnt == 0) begin
      err_cnt++;
      $display("no illegal opcode reached decode during the illegal opcode test");
    end
    report_test("illegal opcodes", errs);
  endtask

  initial begin
    cyc_cnt = 0;
    while (cyc_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("timeout: tests still running after %0d cycles", cyc_cnt);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    arst_n         = 1'b0;
    exe_busy       = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    err_cnt        = 0;
    chk_cnt        = 0;
    ill_cnt        = 0;
    void'($urandom(32'h78fa_4472));
    fill_mem();
    model_reset();
    test_reset();
    test_sequential();
    test_backpressure();
    test_redirect();
    test_fetch_trap();
    test_illegal();
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+sim
hdl/fe_pkg.sv
hdl/pc_gen.sv
hdl/inst_fetch.sv
hdl/pipe_ctrl.sv
hdl/if_id.sv
hdl/inst_decode.sv
hdl/fe_top.sv
sim/tb_fe_top.sv
